//--- design/icache_pkg.sv
// shared geometry, vector types and miss FSM states for the L1 instruction cache and its testbench
`default_nettype none

package icache_pkg;

	// ------------------------------
	// geometry, fixed at 8 KB
	// ------------------------------

	localparam int PA_WIDTH = 34;
	localparam int ICACHE_ASSOC = 2;
	localparam int ICACHE_NUM_SETS = 128;
	localparam int L1_BLOCK_SIZE = 32;
	localparam int ICACHE_FETCH_WIDTH = 16;
	localparam int ICACHE_INDEX_WIDTH = $clog2(ICACHE_NUM_SETS);
	// block address drops the 5 byte offset bits
	localparam int L1_BLOCK_ADDR_WIDTH = PA_WIDTH - $clog2(L1_BLOCK_SIZE);
	localparam int ICACHE_TAG_WIDTH = L1_BLOCK_ADDR_WIDTH - ICACHE_INDEX_WIDTH;
	localparam int L1_BLOCK_SIZE_BITS = L1_BLOCK_SIZE * 8;

	// ------------------------------
	// vector types
	// ------------------------------

	typedef logic [ICACHE_INDEX_WIDTH-1:0] index_t;
	typedef logic [ICACHE_TAG_WIDTH-1:0] tag_t;
	typedef logic [$clog2(ICACHE_ASSOC)-1:0] way_t;
	// selects which 16-byte half of a block is fetched
	typedef logic [$clog2(L1_BLOCK_SIZE / ICACHE_FETCH_WIDTH)-1:0] fetch_offset_t;
	// tag in the upper bits, index in the lower bits
	typedef logic [L1_BLOCK_ADDR_WIDTH-1:0] block_addr_t;
	typedef logic [L1_BLOCK_SIZE_BITS-1:0] block_data_t;
	// byte 0 sits in bits 7:0
	typedef logic [ICACHE_FETCH_WIDTH*8-1:0] fetch_data_t;

	// miss handling steps through idle, request out to L2 and waiting for the fill
	typedef enum logic [1:0] {
		MISS_IDLE,
		MISS_REQ,
		MISS_WAIT
	} miss_state_t;

endpackage

`default_nettype wire

//--- design/icache_tag_array.sv
// per-way valid bits and tags of the instruction cache, written by fills and snoops
`timescale 1ns/1ns
`default_nettype none

module icache_tag_array (
	input logic CLK,
	input logic nRST,

	// read port
	input logic read_valid,
	input icache_pkg::index_t read_index,

	// fill write
	input logic fill_valid,
	input icache_pkg::way_t fill_way,
	input icache_pkg::index_t fill_index,
	input icache_pkg::tag_t fill_tag,

	// snoop invalidate
	input logic inv_valid,
	input icache_pkg::index_t inv_index,
	input icache_pkg::tag_t inv_tag,

	// registered read result
	output logic [icache_pkg::ICACHE_ASSOC-1:0] valid_by_way,
	output icache_pkg::tag_t [icache_pkg::ICACHE_ASSOC-1:0] tag_by_way
);

	// ------------------------------
	// storage
	// ------------------------------

	logic [icache_pkg::ICACHE_NUM_SETS-1:0][icache_pkg::ICACHE_ASSOC-1:0] valid_q;
	icache_pkg::tag_t [icache_pkg::ICACHE_ASSOC-1:0] tags [icache_pkg::ICACHE_NUM_SETS];

	// snoop compares against the tag as it will be after a same-cycle fill
	logic [icache_pkg::ICACHE_ASSOC-1:0] inv_hit;

	always_comb begin
		for (int w = 0; w < icache_pkg::ICACHE_ASSOC; w++) begin
			if (fill_valid && fill_index == inv_index && fill_way == icache_pkg::way_t'(w)) begin
				inv_hit[w] = (fill_tag == inv_tag);
			end else begin
				inv_hit[w] = (tags[inv_index][w] == inv_tag);
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (fill_valid) begin
			tags[fill_index][fill_way] <= fill_tag;
		end
	end

	// snoop clear is applied after the fill set
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
		end else begin
			if (fill_valid) begin
				valid_q[fill_index][fill_way] <= 1'b1;
			end
			if (inv_valid) begin
				for (int w = 0; w < icache_pkg::ICACHE_ASSOC; w++) begin
					if (inv_hit[w]) begin
						valid_q[inv_index][w] <= 1'b0;
					end
				end
			end
		end
	end

	// ------------------------------
	// read registers
	// ------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_by_way <= '0;
		end else if (read_valid) begin
			valid_by_way <= valid_q[read_index];
		end
	end

	always_ff @(posedge CLK) begin
		if (read_valid) begin
			tag_by_way <= tags[read_index];
		end
	end

	// a snoop aimed at the block being replaced must name the incoming block
	a_fill_snoop_collide: assert property (@(posedge CLK) disable iff (!nRST)
		(fill_valid && inv_valid && fill_index == inv_index
			&& valid_q[fill_index][fill_way] && tags[fill_index][fill_way] == inv_tag)
		|-> (fill_tag == inv_tag))
		else $error("snoop hits replaced block while fill writes a different tag");

endmodule

`default_nettype wire

//--- design/icache_data_array.sv
// per-way 32-byte blocks of the instruction cache, filled whole and read back one 16-byte half at a time
`timescale 1ns/1ns
`default_nettype none

module icache_data_array (
	input logic CLK,
	input logic nRST,

	// read port
	input logic read_valid,
	input icache_pkg::index_t read_index,
	input icache_pkg::fetch_offset_t read_offset,

	// full-block fill
	input logic fill_valid,
	input icache_pkg::way_t fill_way,
	input icache_pkg::index_t fill_index,
	input icache_pkg::block_data_t fill_data,

	// selected half of each way
	output icache_pkg::fetch_data_t [icache_pkg::ICACHE_ASSOC-1:0] instr_by_way
);

	icache_pkg::block_data_t [icache_pkg::ICACHE_ASSOC-1:0] blocks [icache_pkg::ICACHE_NUM_SETS];

	// whole set registered on read, half chosen afterwards
	icache_pkg::block_data_t [icache_pkg::ICACHE_ASSOC-1:0] rd_block_q;
	icache_pkg::fetch_offset_t rd_offset_q;

	always_ff @(posedge CLK) begin
		if (fill_valid) begin
			blocks[fill_index][fill_way] <= fill_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (read_valid) begin
			rd_block_q <= blocks[read_index];
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			rd_offset_q <= '0;
		end else if (read_valid) begin
			rd_offset_q <= read_offset;
		end
	end

	// ------------------------------
	// half-block select
	// ------------------------------

	always_comb begin
		for (int w = 0; w < icache_pkg::ICACHE_ASSOC; w++) begin
			instr_by_way[w] = rd_block_q[w][rd_offset_q * $bits(icache_pkg::fetch_data_t)
				+: $bits(icache_pkg::fetch_data_t)];
		end
	end

endmodule

`default_nettype wire

//--- design/icache.sv
// instruction cache core: per-way fetch response, miss request to L2, victim choice and LRU upkeep
`timescale 1ns/1ns
`default_nettype none

module icache (
	input logic CLK,
	input logic nRST,

	// request from core
	input logic core_req_valid,
	input icache_pkg::fetch_offset_t core_req_block_offset,
	input icache_pkg::index_t core_req_index,

	// response to core
	output logic [icache_pkg::ICACHE_ASSOC-1:0] core_resp_valid_by_way,
	output icache_pkg::tag_t [icache_pkg::ICACHE_ASSOC-1:0] core_resp_tag_by_way,
	output icache_pkg::fetch_data_t [icache_pkg::ICACHE_ASSOC-1:0] core_resp_instr_by_way,

	// feedback from core
	input logic core_resp_hit_valid,
	input icache_pkg::way_t core_resp_hit_way,
	input logic core_resp_miss_valid,
	input icache_pkg::tag_t core_resp_miss_tag,

	// request to L2
	output logic l2_req_valid,
	output icache_pkg::block_addr_t l2_req_pa29,
	input logic l2_req_ready,

	// response from L2
	input logic l2_resp_valid,
	input icache_pkg::block_addr_t l2_resp_pa29,
	input icache_pkg::block_data_t l2_resp_data256,

	// snoop invalidate from L2
	input logic l2_snoop_inv_valid,
	input icache_pkg::block_addr_t l2_snoop_inv_pa29
);

	// ------------------------------
	// internal state
	// ------------------------------

	icache_pkg::miss_state_t miss_state, miss_state_next;
	icache_pkg::index_t resp_index_q;
	icache_pkg::block_addr_t miss_addr_q;
	icache_pkg::way_t victim_q;
	icache_pkg::way_t victim;
	logic [icache_pkg::ICACHE_NUM_SETS-1:0] lru_q;

	logic fill_valid;
	icache_pkg::index_t fill_index;
	icache_pkg::tag_t fill_tag;
	icache_pkg::index_t inv_index;
	icache_pkg::tag_t inv_tag;

	// split block addresses into tag and index
	assign fill_index = miss_addr_q[icache_pkg::ICACHE_INDEX_WIDTH-1:0];
	assign fill_tag = miss_addr_q[icache_pkg::ICACHE_INDEX_WIDTH +: icache_pkg::ICACHE_TAG_WIDTH];
	assign inv_index = l2_snoop_inv_pa29[icache_pkg::ICACHE_INDEX_WIDTH-1:0];
	assign inv_tag = l2_snoop_inv_pa29[icache_pkg::ICACHE_INDEX_WIDTH +: icache_pkg::ICACHE_TAG_WIDTH];

	// only the pending block address is taken from L2
	assign fill_valid = (miss_state == icache_pkg::MISS_WAIT) && l2_resp_valid
		&& (l2_resp_pa29 == miss_addr_q);

	assign l2_req_valid = (miss_state == icache_pkg::MISS_REQ);
	assign l2_req_pa29 = miss_addr_q;

	// ------------------------------
	// arrays
	// ------------------------------

	icache_tag_array tag_array (
		.CLK(CLK),
		.nRST(nRST),
		.read_valid(core_req_valid),
		.read_index(core_req_index),
		.fill_valid(fill_valid),
		.fill_way(victim_q),
		.fill_index(fill_index),
		.fill_tag(fill_tag),
		.inv_valid(l2_snoop_inv_valid),
		.inv_index(inv_index),
		.inv_tag(inv_tag),
		.valid_by_way(core_resp_valid_by_way),
		.tag_by_way(core_resp_tag_by_way)
	);

	icache_data_array data_array (
		.CLK(CLK),
		.nRST(nRST),
		.read_valid(core_req_valid),
		.read_index(core_req_index),
		.read_offset(core_req_block_offset),
		.fill_valid(fill_valid),
		.fill_way(victim_q),
		.fill_index(fill_index),
		.fill_data(l2_resp_data256),
		.instr_by_way(core_resp_instr_by_way)
	);

	// index of the response that feedback refers to
	always_ff @(posedge CLK) begin
		if (core_req_valid) begin
			resp_index_q <= core_req_index;
		end
	end

	// first invalid way wins, way 0 first, else the LRU way
	always_comb begin
		victim = lru_q[resp_index_q];
		for (int w = icache_pkg::ICACHE_ASSOC - 1; w >= 0; w--) begin
			if (!core_resp_valid_by_way[w]) begin
				victim = icache_pkg::way_t'(w);
			end
		end
	end

	// ------------------------------
	// miss FSM
	// ------------------------------

	always_comb begin
		miss_state_next = miss_state;
		case (miss_state)
			icache_pkg::MISS_IDLE: if (core_resp_miss_valid) miss_state_next = icache_pkg::MISS_REQ;
			icache_pkg::MISS_REQ: if (l2_req_ready) miss_state_next = icache_pkg::MISS_WAIT;
			icache_pkg::MISS_WAIT: if (fill_valid) miss_state_next = icache_pkg::MISS_IDLE;
			default: miss_state_next = icache_pkg::MISS_IDLE;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			miss_state <= icache_pkg::MISS_IDLE;
		end else begin
			miss_state <= miss_state_next;
		end
	end

	always_ff @(posedge CLK) begin
		if (miss_state == icache_pkg::MISS_IDLE && core_resp_miss_valid) begin
			miss_addr_q <= {core_resp_miss_tag, resp_index_q};
			victim_q <= victim;
		end
	end

	// LRU bit names the way to evict next; fill update wins on the same set
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru_q <= '0;
		end else begin
			if (core_resp_hit_valid) begin
				lru_q[resp_index_q] <= ~core_resp_hit_way;
			end
			if (fill_valid) begin
				lru_q[fill_index] <= ~victim_q;
			end
		end
	end

	a_one_miss: assert property (@(posedge CLK) disable iff (!nRST)
		core_resp_miss_valid |-> miss_state == icache_pkg::MISS_IDLE)
		else $error("miss feedback while a miss is pending");

	a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
		(l2_req_valid && !l2_req_ready) |=> (l2_req_valid && $stable(l2_req_pa29)))
		else $error("L2 request dropped or changed before ready");

endmodule

`default_nettype wire

//--- design/icache_wrapper.sv
// top level of the instruction cache: one register stage on every core, L2 and snoop port
`timescale 1ns/1ns
`default_nettype none

module icache_wrapper (
	input logic CLK,
	input logic nRST,

	// request from core
	input logic next_core_req_valid,
	input icache_pkg::fetch_offset_t next_core_req_block_offset,
	input icache_pkg::index_t next_core_req_index,

	// response to core
	output logic [icache_pkg::ICACHE_ASSOC-1:0] last_core_resp_valid_by_way,
	output icache_pkg::tag_t [icache_pkg::ICACHE_ASSOC-1:0] last_core_resp_tag_by_way,
	output icache_pkg::fetch_data_t [icache_pkg::ICACHE_ASSOC-1:0] last_core_resp_instr_by_way,

	// feedback from core
	input logic next_core_resp_hit_valid,
	input icache_pkg::way_t next_core_resp_hit_way,
	input logic next_core_resp_miss_valid,
	input icache_pkg::tag_t next_core_resp_miss_tag,

	// request to L2
	output logic last_l2_req_valid,
	output icache_pkg::block_addr_t last_l2_req_pa29,
	input logic next_l2_req_ready,

	// response from L2
	input logic next_l2_resp_valid,
	input icache_pkg::block_addr_t next_l2_resp_pa29,
	input icache_pkg::block_data_t next_l2_resp_data256,

	// snoop invalidate from L2
	input logic next_l2_snoop_inv_valid,
	input icache_pkg::block_addr_t next_l2_snoop_inv_pa29
);

	// ------------------------------
	// cache core side
	// ------------------------------

	logic core_req_valid;
	icache_pkg::fetch_offset_t core_req_block_offset;
	icache_pkg::index_t core_req_index;

	logic [icache_pkg::ICACHE_ASSOC-1:0] core_resp_valid_by_way;
	icache_pkg::tag_t [icache_pkg::ICACHE_ASSOC-1:0] core_resp_tag_by_way;
	icache_pkg::fetch_data_t [icache_pkg::ICACHE_ASSOC-1:0] core_resp_instr_by_way;

	logic core_resp_hit_valid;
	icache_pkg::way_t core_resp_hit_way;
	logic core_resp_miss_valid;
	icache_pkg::tag_t core_resp_miss_tag;

	logic l2_req_valid;
	icache_pkg::block_addr_t l2_req_pa29;
	logic l2_req_ready;

	logic l2_resp_valid;
	icache_pkg::block_addr_t l2_resp_pa29;
	icache_pkg::block_data_t l2_resp_data256;

	logic l2_snoop_inv_valid;
	icache_pkg::block_addr_t l2_snoop_inv_pa29;

	icache wrapped_cache (
		.CLK(CLK),
		.nRST(nRST),
		.core_req_valid(core_req_valid),
		.core_req_block_offset(core_req_block_offset),
		.core_req_index(core_req_index),
		.core_resp_valid_by_way(core_resp_valid_by_way),
		.core_resp_tag_by_way(core_resp_tag_by_way),
		.core_resp_instr_by_way(core_resp_instr_by_way),
		.core_resp_hit_valid(core_resp_hit_valid),
		.core_resp_hit_way(core_resp_hit_way),
		.core_resp_miss_valid(core_resp_miss_valid),
		.core_resp_miss_tag(core_resp_miss_tag),
		.l2_req_valid(l2_req_valid),
		.l2_req_pa29(l2_req_pa29),
		.l2_req_ready(l2_req_ready),
		.l2_resp_valid(l2_resp_valid),
		.l2_resp_pa29(l2_resp_pa29),
		.l2_resp_data256(l2_resp_data256),
		.l2_snoop_inv_valid(l2_snoop_inv_valid),
		.l2_snoop_inv_pa29(l2_snoop_inv_pa29)
	);

	// ------------------------------
	// port registers
	// ------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			core_req_valid <= 1'b0;
			core_req_block_offset <= '0;
			core_req_index <= '0;
			last_core_resp_valid_by_way <= '0;
			last_core_resp_tag_by_way <= '0;
			last_core_resp_instr_by_way <= '0;
			core_resp_hit_valid <= 1'b0;
			core_resp_hit_way <= '0;
			core_resp_miss_valid <= 1'b0;
			core_resp_miss_tag <= '0;
			last_l2_req_valid <= 1'b0;
			last_l2_req_pa29 <= '0;
			l2_req_ready <= 1'b0;
			l2_resp_valid <= 1'b0;
			l2_resp_pa29 <= '0;
			l2_resp_data256 <= '0;
			l2_snoop_inv_valid <= 1'b0;
			l2_snoop_inv_pa29 <= '0;
		end else begin
			// inputs toward the core
			core_req_valid <= next_core_req_valid;
			core_req_block_offset <= next_core_req_block_offset;
			core_req_index <= next_core_req_index;
			core_resp_hit_valid <= next_core_resp_hit_valid;
			core_resp_hit_way <= next_core_resp_hit_way;
			core_resp_miss_valid <= next_core_resp_miss_valid;
			core_resp_miss_tag <= next_core_resp_miss_tag;
			l2_req_ready <= next_l2_req_ready;
			l2_resp_valid <= next_l2_resp_valid;
			l2_resp_pa29 <= next_l2_resp_pa29;
			l2_resp_data256 <= next_l2_resp_data256;
			l2_snoop_inv_valid <= next_l2_snoop_inv_valid;
			l2_snoop_inv_pa29 <= next_l2_snoop_inv_pa29;
			// outputs from the core
			last_core_resp_valid_by_way <= core_resp_valid_by_way;
			last_core_resp_tag_by_way <= core_resp_tag_by_way;
			last_core_resp_instr_by_way <= core_resp_instr_by_way;
			last_l2_req_valid <= l2_req_valid;
			last_l2_req_pa29 <= l2_req_pa29;
		end
	end

endmodule

`default_nettype wire

//--- verification/icache_tb.sv
// testbench for the instruction cache wrapper, random traffic checked against a reference model
`timescale 1ns/1ns
`default_nettype none

module icache_tb;

	localparam int N_RANDOM = 300;
	localparam int TOTAL_OPS = N_RANDOM + 20;
	localparam int POOL_SETS = 8;
	localparam int POOL_TAGS = 4;
	localparam int WAIT_LIMIT = 40;

	logic CLK;
	logic nRST;
	logic next_core_req_valid;
	icache_pkg::fetch_offset_t next_core_req_block_offset;
	icache_pkg::index_t next_core_req_index;
	logic next_core_resp_hit_valid;
	icache_pkg::way_t next_core_resp_hit_way;
	logic next_core_resp_miss_valid;
	icache_pkg::tag_t next_core_resp_miss_tag;
	logic next_l2_req_ready;
	logic next_l2_resp_valid;
	icache_pkg::block_addr_t next_l2_resp_pa29;
	icache_pkg::block_data_t next_l2_resp_data256;
	logic next_l2_snoop_inv_valid;
	icache_pkg::block_addr_t next_l2_snoop_inv_pa29;
	logic [icache_pkg::ICACHE_ASSOC-1:0] last_core_resp_valid_by_way;
	icache_pkg::tag_t [icache_pkg::ICACHE_ASSOC-1:0] last_core_resp_tag_by_way;
	icache_pkg::fetch_data_t [icache_pkg::ICACHE_ASSOC-1:0] last_core_resp_instr_by_way;
	logic last_l2_req_valid;
	icache_pkg::block_addr_t last_l2_req_pa29;

	// reference model per set
	logic [icache_pkg::ICACHE_ASSOC-1:0] m_valid [icache_pkg::ICACHE_NUM_SETS];
	icache_pkg::tag_t m_tag [icache_pkg::ICACHE_NUM_SETS][icache_pkg::ICACHE_ASSOC];
	icache_pkg::block_data_t m_data [icache_pkg::ICACHE_NUM_SETS][icache_pkg::ICACHE_ASSOC];
	logic m_lru [icache_pkg::ICACHE_NUM_SETS];

	// small pools so that sets conflict
	icache_pkg::index_t set_pool [POOL_SETS];
	icache_pkg::tag_t tag_pool [POOL_SETS][POOL_TAGS];

	int checks = 0;
	int errors = 0;
	int l2_req_count = 0;
	logic req_seen = 1'b0;
	int lru_victims = 0;
	int free_victims = 0;

	icache_wrapper dut0 (
		.CLK(CLK),
		.nRST(nRST),
		.next_core_req_valid(next_core_req_valid),
		.next_core_req_block_offset(next_core_req_block_offset),
		.next_core_req_index(next_core_req_index),
		.last_core_resp_valid_by_way(last_core_resp_valid_by_way),
		.last_core_resp_tag_by_way(last_core_resp_tag_by_way),
		.last_core_resp_instr_by_way(last_core_resp_instr_by_way),
		.next_core_resp_hit_valid(next_core_resp_hit_valid),
		.next_core_resp_hit_way(next_core_resp_hit_way),
		.next_core_resp_miss_valid(next_core_resp_miss_valid),
		.next_core_resp_miss_tag(next_core_resp_miss_tag),
		.last_l2_req_valid(last_l2_req_valid),
		.last_l2_req_pa29(last_l2_req_pa29),
		.next_l2_req_ready(next_l2_req_ready),
		.next_l2_resp_valid(next_l2_resp_valid),
		.next_l2_resp_pa29(next_l2_resp_pa29),
		.next_l2_resp_data256(next_l2_resp_data256),
		.next_l2_snoop_inv_valid(next_l2_snoop_inv_valid),
		.next_l2_snoop_inv_pa29(next_l2_snoop_inv_pa29)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// counts rising edges of the L2 request
	always @(negedge CLK) begin
		if (last_l2_req_valid && !req_seen) begin
			l2_req_count++;
		end
		req_seen = last_l2_req_valid;
	end

	initial begin
		repeat (TOTAL_OPS * 200) @(posedge CLK);
		$display("run timed out after %0d cycles", TOTAL_OPS * 200);
		$display("CHECKS FAILED");
		$finish;
	end

	// ------------------------------
	// helpers
	// ------------------------------

	task automatic check_value(input logic [255:0] got, input logic [255:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	// L2 block content built word by word from the full block address
	function automatic icache_pkg::block_data_t l2_block(input icache_pkg::block_addr_t pa);
		icache_pkg::block_data_t d;
		for (int i = 0; i < 8; i++) begin
			d[i*32 +: 32] = {3'(i), pa} ^ 32'hc3a50f69;
		end
		return d;
	endfunction

	// response comes back after three edges
	task automatic fetch_and_check(input icache_pkg::index_t idx, input icache_pkg::tag_t tag,
		input icache_pkg::fetch_offset_t off, output logic hit, output icache_pkg::way_t way);
		icache_pkg::fetch_data_t exp_instr;
		hit = 1'b0;
		way = '0;
		@(posedge CLK);
		next_core_req_valid <= 1'b1;
		next_core_req_index <= idx;
		next_core_req_block_offset <= off;
		@(posedge CLK);
		next_core_req_valid <= 1'b0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		for (int w = 0; w < icache_pkg::ICACHE_ASSOC; w++) begin
			check_value(last_core_resp_valid_by_way[w], m_valid[idx][w],
				$sformatf("valid of way %0d in set %0h", w, idx));
			if (m_valid[idx][w]) begin
				exp_instr = off ? m_data[idx][w][255:128] : m_data[idx][w][127:0];
				check_value(last_core_resp_tag_by_way[w], m_tag[idx][w],
					$sformatf("tag of way %0d in set %0h", w, idx));
				check_value(last_core_resp_instr_by_way[w], exp_instr,
					$sformatf("fetch data of way %0d in set %0h", w, idx));
				if (m_tag[idx][w] == tag) begin
					hit = 1'b1;
					way = icache_pkg::way_t'(w);
				end
			end
		end
	endtask

	task automatic send_hit(input icache_pkg::index_t idx, input icache_pkg::way_t way);
		@(posedge CLK);
		next_core_resp_hit_valid <= 1'b1;
		next_core_resp_hit_way <= way;
		@(posedge CLK);
		next_core_resp_hit_valid <= 1'b0;
		m_lru[idx] = ~way;
	endtask

	// miss feedback, then the L2 side of the exchange
	task automatic handle_miss(input icache_pkg::index_t idx, input icache_pkg::tag_t tag,
		input logic stray, input int hold);
		icache_pkg::block_addr_t pa;
		icache_pkg::way_t victim;
		int reqs_before;
		int waited;
		int delay;
		pa = {tag, idx};
		if (!m_valid[idx][0]) begin
			victim = 1'b0;
			free_victims++;
		end else if (!m_valid[idx][1]) begin
			victim = 1'b1;
			free_victims++;
		end else begin
			victim = m_lru[idx];
			lru_victims++;
		end
		reqs_before = l2_req_count;
		@(posedge CLK);
		next_core_resp_miss_valid <= 1'b1;
		next_core_resp_miss_tag <= tag;
		@(posedge CLK);
		next_core_resp_miss_valid <= 1'b0;
		waited = 0;
		@(negedge CLK);
		while (!last_l2_req_valid && waited < WAIT_LIMIT) begin
			@(negedge CLK);
			waited++;
		end
		if (!last_l2_req_valid) begin
			report_failure("no L2 request appeared after miss feedback");
			return;
		end
		check_value(last_l2_req_pa29, pa, "L2 request address");
		repeat (hold) begin
			@(negedge CLK);
			check_value(last_l2_req_valid, 1'b1, "L2 request valid while ready low");
			check_value(last_l2_req_pa29, pa, "L2 request address while ready low");
		end
		// one-cycle ready pulse
		@(posedge CLK);
		next_l2_req_ready <= 1'b1;
		@(posedge CLK);
		next_l2_req_ready <= 1'b0;
		waited = 0;
		@(negedge CLK);
		while (last_l2_req_valid && waited < WAIT_LIMIT) begin
			@(negedge CLK);
			waited++;
		end
		if (last_l2_req_valid) begin
			report_failure("L2 request stayed up after ready");
			return;
		end
		check_value(l2_req_count - reqs_before, 1, "L2 requests for one miss");
		// ready means nothing while the fill is pending
		delay = int'($urandom_range(4));
		repeat (delay) begin
			@(posedge CLK);
			next_l2_req_ready <= 1'($urandom);
		end
		if (stray) begin
			@(posedge CLK);
			next_l2_req_ready <= 1'b0;
			next_l2_resp_valid <= 1'b1;
			next_l2_resp_pa29 <= pa ^ (29'h1 << icache_pkg::ICACHE_INDEX_WIDTH);
			next_l2_resp_data256 <= ~l2_block(pa);
		end
		@(posedge CLK);
		next_l2_req_ready <= 1'b0;
		next_l2_resp_valid <= 1'b1;
		next_l2_resp_pa29 <= pa;
		next_l2_resp_data256 <= l2_block(pa);
		@(posedge CLK);
		next_l2_resp_valid <= 1'b0;
		repeat (2) @(posedge CLK);
		m_valid[idx][victim] = 1'b1;
		m_tag[idx][victim] = tag;
		m_data[idx][victim] = l2_block(pa);
		m_lru[idx] = ~victim;
	endtask

	task automatic snoop_block(input icache_pkg::index_t idx, input icache_pkg::tag_t tag);
		@(posedge CLK);
		next_l2_snoop_inv_valid <= 1'b1;
		next_l2_snoop_inv_pa29 <= {tag, idx};
		@(posedge CLK);
		next_l2_snoop_inv_valid <= 1'b0;
		for (int w = 0; w < icache_pkg::ICACHE_ASSOC; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
				m_valid[idx][w] = 1'b0;
			end
		end
		repeat (2) @(posedge CLK);
	endtask

	// one fetch with the feedback a core would give
	task automatic access_op(input icache_pkg::index_t idx, input icache_pkg::tag_t tag,
		input icache_pkg::fetch_offset_t off);
		logic hit;
		icache_pkg::way_t way;
		fetch_and_check(idx, tag, off, hit, way);
		if (hit) begin
			send_hit(idx, way);
		end else begin
			handle_miss(idx, tag, ($urandom_range(3) == 0), int'($urandom_range(3)));
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin
		int base;
		int s;
		int t;
		logic hit;
		icache_pkg::way_t way;
		icache_pkg::way_t snooped_way;
		icache_pkg::block_data_t fill_block;
		void'($urandom(32'h8bdef408));
		nRST <= 1'b0;
		next_core_req_valid <= 1'b0;
		next_core_req_block_offset <= '0;
		next_core_req_index <= '0;
		next_core_resp_hit_valid <= 1'b0;
		next_core_resp_hit_way <= '0;
		next_core_resp_miss_valid <= 1'b0;
		next_core_resp_miss_tag <= '0;
		next_l2_req_ready <= 1'b0;
		next_l2_resp_valid <= 1'b0;
		next_l2_resp_pa29 <= '0;
		next_l2_resp_data256 <= '0;
		next_l2_snoop_inv_valid <= 1'b0;
		next_l2_snoop_inv_pa29 <= '0;
		for (int i = 0; i < icache_pkg::ICACHE_NUM_SETS; i++) begin
			m_valid[i] = '0;
			m_lru[i] = 1'b0;
		end
		// distinct sets by the top bits, distinct tags by the low bits
		for (int i = 0; i < POOL_SETS; i++) begin
			set_pool[i] = {3'(i), 4'($urandom)};
			for (int j = 0; j < POOL_TAGS; j++) begin
				tag_pool[i][j] = {20'($urandom), 2'(j)};
			end
		end
		repeat (5) @(posedge CLK);
		nRST <= 1'b1;

		base = errors;
		@(negedge CLK);
		check_value(last_core_resp_valid_by_way, 2'b00, "response valids after reset");
		check_value(last_l2_req_valid, 1'b0, "L2 request valid after reset");
		$display("test 1 reset state: %0d errors", errors - base);

		base = errors;
		fetch_and_check(set_pool[1], tag_pool[1][0], 1'b0, hit, way);
		check_value(last_core_resp_valid_by_way, 2'b00, "response valids of a cold set");
		handle_miss(set_pool[1], tag_pool[1][0], 1'b0, 4);
		$display("test 2 cold miss: %0d errors", errors - base);

		base = errors;
		fetch_and_check(set_pool[1], tag_pool[1][0], 1'b1, hit, way);
		check_value(last_core_resp_valid_by_way, 2'b01, "response valids after a cold fill");
		check_value(last_core_resp_tag_by_way[0], tag_pool[1][0], "way 0 tag after a cold fill");
		send_hit(set_pool[1], way);
		fetch_and_check(set_pool[1], tag_pool[1][1], 1'b0, hit, way);
		handle_miss(set_pool[1], tag_pool[1][1], 1'b1, 2);
		fetch_and_check(set_pool[1], tag_pool[1][1], 1'b0, hit, way);
		check_value(last_core_resp_valid_by_way, 2'b11, "response valids after a second fill");
		check_value(last_core_resp_tag_by_way[1], tag_pool[1][1],
			"way 1 tag after a fill with a stray response");
		fill_block = l2_block({tag_pool[1][1], set_pool[1]});
		check_value(last_core_resp_instr_by_way[1], fill_block[127:0],
			"way 1 data after a fill with a stray response");
		send_hit(set_pool[1], way);
		$display("test 3 fill and hit: %0d errors", errors - base);

		base = errors;
		lru_victims = 0;
		free_victims = 0;
		for (int n = 0; n < N_RANDOM; n++) begin
			s = int'($urandom_range(POOL_SETS - 1));
			t = int'($urandom_range(POOL_TAGS - 1));
			if ($urandom_range(9) == 0) begin
				snoop_block(set_pool[s], tag_pool[s][t]);
			end else begin
				access_op(set_pool[s], tag_pool[s][t], 1'($urandom));
			end
		end
		if (lru_victims == 0) begin
			report_failure("random sequence never replaced a valid way by LRU");
		end
		if (free_victims == 0) begin
			report_failure("random sequence never filled an invalid way");
		end
		$display("test 4 replacement: %0d free-way and %0d LRU victims, %0d errors",
			free_victims, lru_victims, errors - base);

		base = errors;
		access_op(set_pool[2], tag_pool[2][0], 1'b0);
		access_op(set_pool[2], tag_pool[2][1], 1'b0);
		fetch_and_check(set_pool[2], tag_pool[2][0], 1'b0, hit, way);
		snooped_way = way;
		snoop_block(set_pool[2], tag_pool[2][0]);
		fetch_and_check(set_pool[2], tag_pool[2][0], 1'b1, hit, way);
		check_value(last_core_resp_valid_by_way[snooped_way], 1'b0, "snooped way after snoop");
		check_value(last_core_resp_valid_by_way[~snooped_way], 1'b1, "other way after snoop");
		$display("test 5 snoop invalidate: %0d errors", errors - base);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache.sv
design/icache_wrapper.sv
verification/icache_tb.sv

//--- Makefile
TOOL = verilator
TOP = icache_tb
FILELIST = verilog.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS = --binary --timing --assert -Wno-fatal
PASS_MSG = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
